/* common/gat_pkg.sv */
/*
 * Sizes for the first-layer H x W feature transform
 * H values and weights are unsigned, FEAT_WIDTH holds 11 full products
 * Column indices above NUM_FEATURE_IN-1 are not legal in the H memory
 */
package gat_pkg;

  // ============================
  // Graph and feature sizes
  // ============================
  localparam int TOTAL_NODES       = 16;
  localparam int NUM_FEATURE_IN    = 11;
  localparam int NUM_FEATURE_OUT   = 4;
  localparam int H_NUM_SPARSE_DATA = 128;

  // ============================
  // Data widths
  // ============================
  localparam int DATA_WIDTH    = 8;
  localparam int COL_IDX_WIDTH = 4;
  // Value in the upper bits, column index in the lower bits
  localparam int H_DATA_WIDTH  = DATA_WIDTH + COL_IDX_WIDTH;
  localparam int ROW_LEN_WIDTH = 4;
  localparam int FEAT_WIDTH    = 20;

  // ============================
  // Depths and address widths
  // ============================
  // Row-major weights, col * NUM_FEATURE_OUT + feature
  localparam int WEIGHT_DEPTH     = NUM_FEATURE_IN * NUM_FEATURE_OUT;
  localparam int FEAT_DEPTH       = TOTAL_NODES * NUM_FEATURE_OUT;
  localparam int H_DATA_ADDR_W    = $clog2(H_NUM_SPARSE_DATA);
  localparam int NODE_INFO_ADDR_W = $clog2(TOTAL_NODES);
  localparam int WEIGHT_ADDR_W    = $clog2(WEIGHT_DEPTH);
  localparam int FEAT_ADDR_W      = $clog2(FEAT_DEPTH);
  localparam int FEAT_COL_W       = $clog2(NUM_FEATURE_OUT);

  // Sequencer states
  localparam int SEQ_STATE_W   = 4;
  localparam int SEQ_IDLE      = 0;
  localparam int SEQ_ROW_START = 1;
  localparam int SEQ_ROW_LEN   = 2;
  localparam int SEQ_FETCH     = 3;
  localparam int SEQ_LATCH     = 4;
  localparam int SEQ_ACC       = 5;
  localparam int SEQ_DRAIN     = 6;
  localparam int SEQ_COMMIT    = 7;
  localparam int SEQ_WAIT_WR   = 8;

endpackage

/* rtl/dual_port_bram.sv */
`timescale 1ns/100ps

/*
 * Simple dual-port block memory
 * Port A writes when ena and wea are both high
 * Port B reads with one clock of latency, no reset on the read data
 */
module dual_port_bram #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  logic                     clk,
  input  logic                     ena,
  input  logic                     wea,
  input  logic [$clog2(DEPTH)-1:0] addra,
  input  logic [WIDTH-1:0]         din,
  input  logic [$clog2(DEPTH)-1:0] addrb,
  output logic [WIDTH-1:0]         dout
);

  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (ena && wea) begin
      mem[addra] <= din;
    end
  end

  // Registered read
  always_ff @(posedge clk) begin
    dout <= mem[addrb];
  end

endmodule

/* conv/conv_sequencer.sv */
`timescale 1ns/100ps

/*
 * Walks all nodes in order with one running CSR pointer, so the row
 * lengths must add up to the number of stored H entries
 * Each nonzero entry takes two fetch cycles and NUM_FEATURE_OUT MAC cycles
 * A run starts when all load-done flags are high and gat_ready is low
 */
module conv_sequencer (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  h_data_bram_load_done,
  input  logic                                  h_node_info_bram_load_done,
  input  logic                                  wgt_bram_load_done,
  output logic [gat_pkg::NODE_INFO_ADDR_W-1:0]  node_info_addrb,
  input  logic [gat_pkg::ROW_LEN_WIDTH-1:0]     node_info_dout,
  output logic [gat_pkg::H_DATA_ADDR_W-1:0]     h_data_addrb,
  input  logic [gat_pkg::H_DATA_WIDTH-1:0]      h_data_dout,
  output logic [gat_pkg::WEIGHT_ADDR_W-1:0]     wgt_addrb,
  output logic                                  mac_clear,
  output logic                                  mac_start,
  output logic                                  mac_valid,
  output logic [gat_pkg::FEAT_COL_W-1:0]        mac_col,
  output logic [gat_pkg::DATA_WIDTH-1:0]        h_value,
  output logic                                  row_done,
  input  logic                                  write_busy,
  output logic                                  gat_ready
);
  import gat_pkg::*;

  logic [SEQ_STATE_W-1:0]      state;
  logic [NODE_INFO_ADDR_W-1:0] node_cnt;
  logic [H_DATA_ADDR_W-1:0]    csr_ptr;
  logic [ROW_LEN_WIDTH-1:0]    remaining;
  logic [FEAT_COL_W-1:0]       feat_cnt;
  logic [COL_IDX_WIDTH-1:0]    col_idx;
  logic                        all_done;

  assign all_done = h_data_bram_load_done && h_node_info_bram_load_done && wgt_bram_load_done;

  assign node_info_addrb = node_cnt;
  assign h_data_addrb    = csr_ptr;
  assign wgt_addrb       = WEIGHT_ADDR_W'(col_idx) * WEIGHT_ADDR_W'(NUM_FEATURE_OUT)
                         + WEIGHT_ADDR_W'(feat_cnt);

  assign mac_clear = (state == SEQ_STATE_W'(SEQ_ROW_START));
  assign mac_start = mac_clear && (node_cnt == '0);
  assign row_done  = (state == SEQ_STATE_W'(SEQ_COMMIT));

  // ============================
  // Control FSM
  // ============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= SEQ_STATE_W'(SEQ_IDLE);
      node_cnt  <= '0;
      csr_ptr   <= '0;
      remaining <= '0;
      feat_cnt  <= '0;
      gat_ready <= 1'b0;
      mac_valid <= 1'b0;
      mac_col   <= '0;
    end else begin
      // Lines up with the weight read data
      mac_valid <= (state == SEQ_STATE_W'(SEQ_ACC));
      mac_col   <= feat_cnt;
      case (state)
        SEQ_STATE_W'(SEQ_IDLE): begin
          if (!all_done) begin
            gat_ready <= 1'b0;
          end else if (!gat_ready) begin
            node_cnt <= '0;
            csr_ptr  <= '0;
            state    <= SEQ_STATE_W'(SEQ_ROW_START);
          end
        end
        SEQ_STATE_W'(SEQ_ROW_START): state <= SEQ_STATE_W'(SEQ_ROW_LEN);
        SEQ_STATE_W'(SEQ_ROW_LEN): begin
          remaining <= node_info_dout;
          state     <= (node_info_dout == '0) ? SEQ_STATE_W'(SEQ_COMMIT)
                                              : SEQ_STATE_W'(SEQ_FETCH);
        end
        SEQ_STATE_W'(SEQ_FETCH): state <= SEQ_STATE_W'(SEQ_LATCH);
        SEQ_STATE_W'(SEQ_LATCH): begin
          csr_ptr   <= csr_ptr + 1'b1;
          remaining <= remaining - 1'b1;
          feat_cnt  <= '0;
          state     <= SEQ_STATE_W'(SEQ_ACC);
        end
        SEQ_STATE_W'(SEQ_ACC): begin
          feat_cnt <= feat_cnt + 1'b1;
          if (feat_cnt == FEAT_COL_W'(NUM_FEATURE_OUT - 1)) begin
            state <= (remaining == '0) ? SEQ_STATE_W'(SEQ_DRAIN) : SEQ_STATE_W'(SEQ_FETCH);
          end
        end
        // Last product still in flight
        SEQ_STATE_W'(SEQ_DRAIN):  state <= SEQ_STATE_W'(SEQ_COMMIT);
        SEQ_STATE_W'(SEQ_COMMIT): state <= SEQ_STATE_W'(SEQ_WAIT_WR);
        SEQ_STATE_W'(SEQ_WAIT_WR): begin
          if (!write_busy) begin
            if (node_cnt == NODE_INFO_ADDR_W'(TOTAL_NODES - 1)) begin
              gat_ready <= 1'b1;
              state     <= SEQ_STATE_W'(SEQ_IDLE);
            end else begin
              node_cnt <= node_cnt + 1'b1;
              state    <= SEQ_STATE_W'(SEQ_ROW_START);
            end
          end
        end
        default: state <= SEQ_STATE_W'(SEQ_IDLE);
      endcase
    end
  end

  // Current H entry
  always_ff @(posedge clk) begin
    if (state == SEQ_STATE_W'(SEQ_LATCH)) begin
      h_value <= h_data_dout[H_DATA_WIDTH-1 -: DATA_WIDTH];
      col_idx <= h_data_dout[COL_IDX_WIDTH-1:0];
    end
  end

  // Stored column index must address a real row of W
  assert property (@(posedge clk) disable iff (!rst_n)
    (state == SEQ_STATE_W'(SEQ_LATCH)) |-> (h_data_dout[COL_IDX_WIDTH-1:0] < NUM_FEATURE_IN));

endmodule

/* conv/feature_mac.sv */
`timescale 1ns/100ps

/*
 * One accumulator per output feature, cleared by mac_clear
 * row_done drains the sums as NUM_FEATURE_OUT consecutive writes
 * Write address restarts at 0 on mac_start and then runs on across rows
 */
module feature_mac (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             mac_clear,
  input  logic                             mac_start,
  input  logic                             mac_valid,
  input  logic [gat_pkg::FEAT_COL_W-1:0]   mac_col,
  input  logic [gat_pkg::DATA_WIDTH-1:0]   h_value,
  input  logic [gat_pkg::DATA_WIDTH-1:0]   wgt_dout,
  input  logic                             row_done,
  output logic                             feat_ena,
  output logic [gat_pkg::FEAT_ADDR_W-1:0]  feat_addra,
  output logic [gat_pkg::FEAT_WIDTH-1:0]   feat_din,
  output logic                             write_busy
);
  import gat_pkg::*;

  logic [FEAT_WIDTH-1:0]     acc [NUM_FEATURE_OUT];
  logic [2*DATA_WIDTH-1:0]   product;
  logic [FEAT_COL_W-1:0]     wr_left;

  assign product  = h_value * wgt_dout;
  assign feat_din = acc[0];
  assign feat_ena = write_busy;

  // ============================
  // Accumulate and drain
  // ============================
  always_ff @(posedge clk) begin
    if (mac_clear) begin
      for (int i = 0; i < NUM_FEATURE_OUT; i++) begin
        acc[i] <= '0;
      end
    end else if (mac_valid) begin
      acc[mac_col] <= acc[mac_col] + FEAT_WIDTH'(product);
    end else if (write_busy) begin
      // Next sum moves to the head
      for (int i = 0; i < NUM_FEATURE_OUT - 1; i++) begin
        acc[i] <= acc[i+1];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      write_busy <= 1'b0;
      wr_left    <= '0;
      feat_addra <= '0;
    end else begin
      if (mac_start) begin
        feat_addra <= '0;
      end else if (write_busy) begin
        feat_addra <= feat_addra + 1'b1;
      end

      if (row_done) begin
        write_busy <= 1'b1;
        wr_left    <= FEAT_COL_W'(NUM_FEATURE_OUT - 1);
      end else if (write_busy) begin
        if (wr_left == '0) begin
          write_busy <= 1'b0;
        end else begin
          wr_left <= wr_left - 1'b1;
        end
      end
    end
  end

  // Sequencer must wait for the previous row to drain
  assert property (@(posedge clk) disable iff (!rst_n) row_done |-> !write_busy);

endmodule

/* rtl/gat_top.sv */
`timescale 1ns/100ps

/*
 * Feature transform core: sparse H (CSR) times dense W
 * Host fills the three input memories, then holds all load-done flags high
 * gat_ready stays high until a load-done flag falls
 * Results read through feat_bram_addrb, one clock of read latency
 */
module gat_top (
  input  logic                                  clk,
  input  logic                                  rst_n,

  input  logic [gat_pkg::H_DATA_WIDTH-1:0]      h_data_bram_din,
  input  logic                                  h_data_bram_ena,
  input  logic                                  h_data_bram_wea,
  input  logic [gat_pkg::H_DATA_ADDR_W-1:0]     h_data_bram_addra,

  input  logic [gat_pkg::ROW_LEN_WIDTH-1:0]     h_node_info_bram_din,
  input  logic                                  h_node_info_bram_ena,
  input  logic                                  h_node_info_bram_wea,
  input  logic [gat_pkg::NODE_INFO_ADDR_W-1:0]  h_node_info_bram_addra,

  input  logic [gat_pkg::DATA_WIDTH-1:0]        wgt_bram_din,
  input  logic                                  wgt_bram_ena,
  input  logic                                  wgt_bram_wea,
  input  logic [gat_pkg::WEIGHT_ADDR_W-1:0]     wgt_bram_addra,

  input  logic                                  h_data_bram_load_done,
  input  logic                                  h_node_info_bram_load_done,
  input  logic                                  wgt_bram_load_done,

  input  logic [gat_pkg::FEAT_ADDR_W-1:0]       feat_bram_addrb,
  output logic [gat_pkg::FEAT_WIDTH-1:0]        feat_bram_dout,
  output logic                                  gat_ready
);
  import gat_pkg::*;

  logic [H_DATA_ADDR_W-1:0]    h_data_addrb;
  logic [H_DATA_WIDTH-1:0]     h_data_dout;
  logic [NODE_INFO_ADDR_W-1:0] node_info_addrb;
  logic [ROW_LEN_WIDTH-1:0]    node_info_dout;
  logic [WEIGHT_ADDR_W-1:0]    wgt_addrb;
  logic [DATA_WIDTH-1:0]       wgt_dout;

  logic                        mac_clear;
  logic                        mac_start;
  logic                        mac_valid;
  logic [FEAT_COL_W-1:0]       mac_col;
  logic [DATA_WIDTH-1:0]       h_value;
  logic                        row_done;
  logic                        write_busy;

  logic                        feat_ena;
  logic [FEAT_ADDR_W-1:0]      feat_addra;
  logic [FEAT_WIDTH-1:0]       feat_din;

  // ============================
  // Memories
  // ============================
  dual_port_bram #(.WIDTH(H_DATA_WIDTH), .DEPTH(H_NUM_SPARSE_DATA)) u_h_data_bram (
    .clk   (clk),
    .ena   (h_data_bram_ena),
    .wea   (h_data_bram_wea),
    .addra (h_data_bram_addra),
    .din   (h_data_bram_din),
    .addrb (h_data_addrb),
    .dout  (h_data_dout)
  );

  dual_port_bram #(.WIDTH(ROW_LEN_WIDTH), .DEPTH(TOTAL_NODES)) u_node_info_bram (
    .clk   (clk),
    .ena   (h_node_info_bram_ena),
    .wea   (h_node_info_bram_wea),
    .addra (h_node_info_bram_addra),
    .din   (h_node_info_bram_din),
    .addrb (node_info_addrb),
    .dout  (node_info_dout)
  );

  dual_port_bram #(.WIDTH(DATA_WIDTH), .DEPTH(WEIGHT_DEPTH)) u_weight_bram (
    .clk   (clk),
    .ena   (wgt_bram_ena),
    .wea   (wgt_bram_wea),
    .addra (wgt_bram_addra),
    .din   (wgt_bram_din),
    .addrb (wgt_addrb),
    .dout  (wgt_dout)
  );

  // Core owns port A, host reads port B
  dual_port_bram #(.WIDTH(FEAT_WIDTH), .DEPTH(FEAT_DEPTH)) u_feature_bram (
    .clk   (clk),
    .ena   (feat_ena),
    .wea   (1'b1),
    .addra (feat_addra),
    .din   (feat_din),
    .addrb (feat_bram_addrb),
    .dout  (feat_bram_dout)
  );

  // ============================
  // Conv core
  // ============================
  conv_sequencer u_conv_sequencer (.*);

  feature_mac u_feature_mac (.*);

  // Host must leave the memories alone between start and gat_ready
  assert property (@(posedge clk) disable iff (!rst_n)
    (h_data_bram_load_done && h_node_info_bram_load_done && wgt_bram_load_done && !gat_ready)
    |-> !((h_data_bram_ena && h_data_bram_wea) || (wgt_bram_ena && wgt_bram_wea) ||
          (h_node_info_bram_ena && h_node_info_bram_wea)));

endmodule

/* verif/tb_gat_top.sv */
`timescale 1ns/100ps

/*
 * Testbench for gat_top with random CSR loads from a fixed seed
 * First run forces an empty row and a row of seven 255 x 255 products
 * Second run reloads fresh random data after one load-done flag drops
 * Stops at the first mismatch
 */
module tb_gat_top;
  import gat_pkg::*;

  localparam int MAX_ROW_LEN       = 7;
  localparam int ZERO_NODE         = 5;
  localparam int FULL_NODE         = 9;
  localparam int IDLE_CHECK_CYCLES = 20;
  localparam int NUM_FLAGS         = 3;
  localparam int NUM_RUNS          = 2;
  // Per row: start, length, drain, commit, wait and the feature writes
  localparam int RUN_CYCLES  = TOTAL_NODES *
                               (5 + NUM_FEATURE_OUT + MAX_ROW_LEN * (2 + NUM_FEATURE_OUT));
  localparam int LOAD_CYCLES = H_NUM_SPARSE_DATA + TOTAL_NODES + WEIGHT_DEPTH + FEAT_DEPTH +
                               NUM_FLAGS * IDLE_CHECK_CYCLES + 20;
  localparam int MAX_CYCLES  = NUM_RUNS * (3 * RUN_CYCLES + LOAD_CYCLES);

  logic                        clk;
  logic                        rst_n;
  logic [H_DATA_WIDTH-1:0]     h_data_bram_din;
  logic                        h_data_bram_ena;
  logic                        h_data_bram_wea;
  logic [H_DATA_ADDR_W-1:0]    h_data_bram_addra;
  logic [ROW_LEN_WIDTH-1:0]    h_node_info_bram_din;
  logic                        h_node_info_bram_ena;
  logic                        h_node_info_bram_wea;
  logic [NODE_INFO_ADDR_W-1:0] h_node_info_bram_addra;
  logic [DATA_WIDTH-1:0]       wgt_bram_din;
  logic                        wgt_bram_ena;
  logic                        wgt_bram_wea;
  logic [WEIGHT_ADDR_W-1:0]    wgt_bram_addra;
  logic                        h_data_bram_load_done;
  logic                        h_node_info_bram_load_done;
  logic                        wgt_bram_load_done;
  logic [FEAT_ADDR_W-1:0]      feat_bram_addrb;
  logic [FEAT_WIDTH-1:0]       feat_bram_dout;
  logic                        gat_ready;

  // Reference copy of the loaded graph
  int     row_len [TOTAL_NODES];
  int     h_val [H_NUM_SPARSE_DATA];
  int     h_col [H_NUM_SPARSE_DATA];
  int     wgt [WEIGHT_DEPTH];
  int     n_entries;
  integer seed;
  int     cycle_cnt = 0;

  gat_top uut (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: gat_ready never came within %0d cycles", MAX_CYCLES);
      abort_run("timeout");
    end
  end

  // ==============================
  // Helpers
  // ==============================
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic abort_run(input string reason);
    $display(">>> FAIL");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_ready(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      $display("ERROR at %0t: gat_ready is %b, expected %b (%s)", $time, actual, expected, what);
      abort_run("gat_ready mismatch");
    end
  endtask

  task automatic check_feature(input int node, input int feat,
                               input logic [FEAT_WIDTH-1:0] actual,
                               input logic [FEAT_WIDTH-1:0] expected);
    if (actual !== expected) begin
      $display("ERROR at %0t: node %0d feature %0d is %0d, expected %0d",
               $time, node, feat, actual, expected);
      abort_run("feature mismatch");
    end
  endtask

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic build_data(input bit special);
    n_entries = 0;
    for (int n = 0; n < TOTAL_NODES; n++) begin
      row_len[n] = rand_below(MAX_ROW_LEN + 1);
      if (special && n == ZERO_NODE) row_len[n] = 0;
      if (special && n == FULL_NODE) row_len[n] = MAX_ROW_LEN;
      for (int k = 0; k < row_len[n]; k++) begin
        if (special && n == FULL_NODE) begin
          h_val[n_entries] = 255;
          h_col[n_entries] = k;
        end else begin
          h_val[n_entries] = rand_below(256);
          h_col[n_entries] = rand_below(NUM_FEATURE_IN);
        end
        n_entries++;
      end
    end
    for (int c = 0; c < NUM_FEATURE_IN; c++) begin
      for (int f = 0; f < NUM_FEATURE_OUT; f++) begin
        wgt[c * NUM_FEATURE_OUT + f] = (special && c < MAX_ROW_LEN) ? 255 : rand_below(256);
      end
    end
  endtask

  task automatic load_memories();
    for (int n = 0; n < TOTAL_NODES; n++) begin
      h_node_info_bram_ena   = 1'b1;
      h_node_info_bram_wea   = 1'b1;
      h_node_info_bram_addra = NODE_INFO_ADDR_W'(n);
      h_node_info_bram_din   = ROW_LEN_WIDTH'(row_len[n]);
      step();
    end
    h_node_info_bram_ena = 1'b0;
    h_node_info_bram_wea = 1'b0;
    for (int i = 0; i < n_entries; i++) begin
      h_data_bram_ena   = 1'b1;
      h_data_bram_wea   = 1'b1;
      h_data_bram_addra = H_DATA_ADDR_W'(i);
      h_data_bram_din   = {DATA_WIDTH'(h_val[i]), COL_IDX_WIDTH'(h_col[i])};
      step();
    end
    h_data_bram_ena = 1'b0;
    h_data_bram_wea = 1'b0;
    for (int a = 0; a < WEIGHT_DEPTH; a++) begin
      wgt_bram_ena   = 1'b1;
      wgt_bram_wea   = 1'b1;
      wgt_bram_addra = WEIGHT_ADDR_W'(a);
      wgt_bram_din   = DATA_WIDTH'(wgt[a]);
      step();
    end
    wgt_bram_ena = 1'b0;
    wgt_bram_wea = 1'b0;
  endtask

  // Sum over the row of value times W[col][feat]
  function automatic logic [FEAT_WIDTH-1:0] model_feature(input int node, input int feat);
    int ptr;
    int sum;
    ptr = 0;
    sum = 0;
    for (int n = 0; n < node; n++) ptr += row_len[n];
    for (int k = 0; k < row_len[node]; k++) begin
      sum += h_val[ptr + k] * wgt[h_col[ptr + k] * NUM_FEATURE_OUT + feat];
    end
    return FEAT_WIDTH'(sum);
  endfunction

  task automatic read_feature(input int node, input int feat, output logic [FEAT_WIDTH-1:0] value);
    feat_bram_addrb = FEAT_ADDR_W'(node * NUM_FEATURE_OUT + feat);
    step();
    value = feat_bram_dout;
  endtask

  task automatic check_all_features();
    logic [FEAT_WIDTH-1:0] value;
    for (int n = 0; n < TOTAL_NODES; n++) begin
      for (int f = 0; f < NUM_FEATURE_OUT; f++) begin
        read_feature(n, f, value);
        check_feature(n, f, value, model_feature(n, f));
      end
    end
  endtask

  task automatic wait_ready();
    while (gat_ready !== 1'b1) step();
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial begin
    logic [FEAT_WIDTH-1:0] value;
    seed                       = 26428;
    rst_n                      = 1'b0;
    h_data_bram_din            = '0;
    h_data_bram_ena            = 1'b0;
    h_data_bram_wea            = 1'b0;
    h_data_bram_addra          = '0;
    h_node_info_bram_din       = '0;
    h_node_info_bram_ena       = 1'b0;
    h_node_info_bram_wea       = 1'b0;
    h_node_info_bram_addra     = '0;
    wgt_bram_din               = '0;
    wgt_bram_ena               = 1'b0;
    wgt_bram_wea               = 1'b0;
    wgt_bram_addra             = '0;
    h_data_bram_load_done      = 1'b0;
    h_node_info_bram_load_done = 1'b0;
    wgt_bram_load_done         = 1'b0;
    feat_bram_addrb            = '0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    step();
    check_ready(gat_ready, 1'b0, "after reset");

    // Each load-done flag held back in turn, the weight flag last
    build_data(1'b1);
    load_memories();
    for (int low = 0; low < NUM_FLAGS; low++) begin
      h_data_bram_load_done      = (low != 0);
      h_node_info_bram_load_done = (low != 1);
      wgt_bram_load_done         = (low != 2);
      repeat (IDLE_CHECK_CYCLES) begin
        step();
        check_ready(gat_ready, 1'b0, "one load-done flag still low");
      end
    end
    wgt_bram_load_done = 1'b1;
    wait_ready();
    check_all_features();
    for (int f = 0; f < NUM_FEATURE_OUT; f++) begin
      read_feature(ZERO_NODE, f, value);
      check_feature(ZERO_NODE, f, value, '0);
      read_feature(FULL_NODE, f, value);
      check_feature(FULL_NODE, f, value, FEAT_WIDTH'(MAX_ROW_LEN * 255 * 255));
    end

    // Second run on fresh data
    wgt_bram_load_done = 1'b0;
    step();
    check_ready(gat_ready, 1'b0, "after load-done drop");
    build_data(1'b0);
    load_memories();
    wgt_bram_load_done = 1'b1;
    wait_ready();
    check_all_features();

    $display(">>> PASS");
    $finish;
  end

endmodule

/* vlog.f */
common/gat_pkg.sv
rtl/dual_port_bram.sv
conv/conv_sequencer.sv
conv/feature_mac.sv
rtl/gat_top.sv
verif/tb_gat_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run tb_gat_top with Verilator; exit status follows the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -Wno-fatal --top-module tb_gat_top \
  -Mdir obj_dir -f vlog.f || { echo "Build failed"; exit 1; }

out=$(./obj_dir/Vtb_gat_top)
echo "$out"
echo "$out" | grep -qx ">>> PASS" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
